// ==== compile.f ====
+incdir+verilog
verilog/bev_pkg.sv
verilog/bev_order_capture.sv
verilog/bev_recipe.sv
verilog/bev_controller.sv
verilog/bev_dram_port.sv
verilog/bev_top.sv
tests/bev_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -f compile.f \
    --top-module bev_tb -o bev_sim &&
{ out="$(./obj_dir/bev_sim)"; echo "$out"; } &&
grep -q "Simulation passed" <<< "$out" ||
{ echo "Run did not report a pass"; exit 1; }

// ==== tests/bev_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bev_settings.svh"

module bev_tb
    import bev_pkg::*;
();

    localparam int NUM_ORDERS = 300;
    localparam int WAIT_LIMIT = 100;

    logic     clk;
    logic     inf;
    logic     action_valid;
    logic     type_valid;
    logic     size_valid;
    logic     date_valid;
    logic     box_valid;
    in_data_t in_data;
    logic     c_out_valid;
    record_t  c_data_r;
    logic     out_valid;
    err_t     err_msg;
    logic     complete;
    logic     c_in_valid;
    logic     c_r_wb;
    box_t     c_addr;
    record_t  c_data_w;

    logic [31:0] rng_state;

    // External memory contents and the model's copy
    record_t mem [0:255];
    record_t ref_mem [0:255];

    logic    mem_busy;
    int      mem_delay;
    logic    mem_write;
    box_t    mem_addr;
    record_t mem_wdata;

    logic    expect_write;
    box_t    expect_box;
    record_t expect_rec;
    int      out_count;
    int      req_count;
    int      write_count;
    err_t    got_err;
    logic    got_complete;
    err_t    seen_err;
    logic    seen_complete;
    int      count_ok;
    int      count_exp;
    int      count_ing;

    bev_top uut (
        .clk          (clk),
        .inf          (inf),
        .action_valid (action_valid),
        .type_valid   (type_valid),
        .size_valid   (size_valid),
        .date_valid   (date_valid),
        .box_valid    (box_valid),
        .in_data      (in_data),
        .c_out_valid  (c_out_valid),
        .c_data_r     (c_data_r),
        .out_valid    (out_valid),
        .err_msg      (err_msg),
        .complete     (complete),
        .c_in_valid   (c_in_valid),
        .c_r_wb       (c_r_wb),
        .c_addr       (c_addr),
        .c_data_w     (c_data_w)
    );

    initial
        clk = 1'b0;

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        rng_state = xorshift(rng_state);
        return rng_state % n;
    endfunction

    // Some boxes start nearly empty so that shortages show up
    function automatic ing_t random_amount();
        if (rand_below(8) == 0)
            return ing_t'(rand_below(300));
        return ing_t'(rand_below(`BEV_ING_MAX + 1));
    endfunction

    function automatic err_t model_result(input action_t act, input bev_type_t typ,
                                          input bev_size_t sz, input date_t dt,
                                          input record_t rec, output record_t red);
        int vol;
        int blk;
        int grn;
        int mlk;
        int pin;
        red = rec;
        case (sz)
            M:       vol = `BEV_VOL_M;
            L:       vol = `BEV_VOL_L;
            default: vol = `BEV_VOL_S;
        endcase
        blk = 0;
        grn = 0;
        mlk = 0;
        pin = 0;
        case (typ)
            Black_Tea:
                blk = vol;
            Milk_Tea:
            begin
                blk = vol * 3 / 4;
                mlk = vol / 4;
            end
            Extra_Milk_Tea:
            begin
                blk = vol / 2;
                mlk = vol / 2;
            end
            Green_Tea:
                grn = vol;
            Green_Milk_Tea:
            begin
                grn = vol / 2;
                mlk = vol / 2;
            end
            Pineapple_Juice:
                pin = vol;
            Super_Pineapple_Tea:
            begin
                blk = vol / 2;
                pin = vol / 2;
            end
            default:
            begin
                blk = vol / 2;
                pin = vol / 4;
                mlk = vol / 4;
            end
        endcase
        // Expiry day itself still counts as good
        if (rec.exp_month < dt.month || (rec.exp_month == dt.month && rec.exp_day < dt.day))
            return No_Exp;
        if (act == Check_valid_date)
            return No_Err;
        if (blk > int'(rec.black_tea) || grn > int'(rec.green_tea) ||
            mlk > int'(rec.milk) || pin > int'(rec.pineapple_juice))
            return No_Ing;
        red.black_tea       = ing_t'(int'(rec.black_tea) - blk);
        red.green_tea       = ing_t'(int'(rec.green_tea) - grn);
        red.milk            = ing_t'(int'(rec.milk) - mlk);
        red.pineapple_juice = ing_t'(int'(rec.pineapple_juice) - pin);
        return No_Err;
    endfunction

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_err(input string name, input err_t expected, input err_t actual);
        if (actual !== expected)
        begin
            $display("[FAIL] %s: expected %s, actual %s", name, expected.name(), actual.name());
            abort_run();
        end
    endtask

    task automatic check_complete(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("[FAIL] %s: expected %0b, actual %0b", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_record(input string name, input record_t expected,
                                input record_t actual);
        if (actual !== expected)
        begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_box(input string name, input box_t expected, input box_t actual);
        if (actual !== expected)
        begin
            $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
            abort_run();
        end
    endtask

    // Sample on the falling edge, drive on the rising edge
    task automatic tick();
        logic respond;
        respond = 1'b0;
        @(negedge clk);
        seen_err      = err_msg;
        seen_complete = complete;
        if (out_valid)
        begin
            out_count++;
            got_err      = err_msg;
            got_complete = complete;
        end
        if (c_in_valid)
        begin
            if (mem_busy)
            begin
                $display("Memory request issued while another one was still open");
                abort_run();
            end
            req_count++;
            mem_busy  = 1'b1;
            mem_delay = 1 + rand_below(4);
            mem_write = !c_r_wb;
            mem_addr  = c_addr;
            mem_wdata = c_data_w;
            check_box("memory address", expect_box, c_addr);
            if (!c_r_wb)
            begin
                write_count++;
                if (!expect_write)
                begin
                    $display("Unexpected memory write to box %0d", c_addr);
                    abort_run();
                end
                check_record("write data", expect_rec, c_data_w);
                expect_write = 1'b0;
            end
        end
        // A delay of one answers in the cycle right after the request
        if (mem_busy)
        begin
            mem_delay--;
            if (mem_delay == 0)
            begin
                respond  = 1'b1;
                mem_busy = 1'b0;
                if (mem_write)
                    mem[mem_addr] = mem_wdata;
            end
        end
        @(posedge clk);
        action_valid <= 1'b0;
        type_valid   <= 1'b0;
        size_valid   <= 1'b0;
        date_valid   <= 1'b0;
        box_valid    <= 1'b0;
        c_out_valid  <= respond;
        if (respond && !mem_write)
            c_data_r <= mem[mem_addr];
    endtask

    // Field index is action, type, size, date, box
    task automatic send_field(input int which, input in_data_t d);
        repeat (rand_below(4)) tick();
        tick();
        case (which)
            0: action_valid <= 1'b1;
            1: type_valid   <= 1'b1;
            2: size_valid   <= 1'b1;
            3: date_valid   <= 1'b1;
            4: box_valid    <= 1'b1;
            default: ;
        endcase
        in_data <= d;
    endtask

    task automatic run_order(input int n);
        action_t   act;
        bev_type_t typ;
        bev_size_t sz;
        date_t     dt;
        box_t      bx;
        record_t   red;
        err_t      want;
        logic      wrote;
        int        waited;
        string     tag;

        act      = action_t'(1'(rand_below(2)));
        typ      = bev_type_t'(3'(rand_below(8)));
        sz       = bev_size_t'(2'(rand_below(3)));
        dt.month = month_t'(1 + rand_below(12));
        dt.day   = day_t'(1 + rand_below(31));
        bx       = box_t'(rand_below(32));
        tag      = $sformatf("order %0d", n);

        want         = model_result(act, typ, sz, dt, ref_mem[bx], red);
        wrote        = (act == Make_drink && want == No_Err);
        expect_write = wrote;
        expect_box   = bx;
        expect_rec   = red;
        out_count    = 0;
        req_count    = 0;
        write_count  = 0;

        send_field(0, in_data_t'(act));
        if (act == Make_drink)
        begin
            send_field(1, in_data_t'(typ));
            send_field(2, in_data_t'(sz));
        end
        send_field(3, in_data_t'(dt));
        send_field(4, in_data_t'(bx));

        waited = 0;
        while (out_count == 0)
        begin
            tick();
            waited++;
            if (waited > WAIT_LIMIT)
            begin
                $display("Timeout while waiting for out_valid in %s", tag);
                abort_run();
            end
        end
        check_err({tag, " err_msg"}, want, got_err);
        check_complete({tag, " complete"}, want == No_Err, got_complete);

        // Quiet cycles catch a second pulse or a stray request
        repeat (3) tick();
        if (out_count != 1 || mem_busy)
        begin
            $display("%s gave %0d result pulses or left a request open", tag, out_count);
            abort_run();
        end
        if (req_count != (wrote ? 2 : 1))
        begin
            $display("[FAIL] %s requests: expected %0d, actual %0d", tag,
                     wrote ? 2 : 1, req_count);
            abort_run();
        end
        if (write_count != (wrote ? 1 : 0))
        begin
            $display("[FAIL] %s writes: expected %0d, actual %0d", tag,
                     wrote ? 1 : 0, write_count);
            abort_run();
        end
        if (wrote)
            ref_mem[bx] = red;
        check_record({tag, " memory"}, ref_mem[bx], mem[bx]);

        case (want)
            No_Exp:  count_exp++;
            No_Ing:  count_ing++;
            default: count_ok++;
        endcase
    endtask

    initial
    begin
        record_t rec;
        int      i;

        inf          <= 1'b0;
        action_valid <= 1'b0;
        type_valid   <= 1'b0;
        size_valid   <= 1'b0;
        date_valid   <= 1'b0;
        box_valid    <= 1'b0;
        in_data      <= '0;
        c_out_valid  <= 1'b0;
        c_data_r     <= '0;

        rng_state    = 32'd76;
        mem_busy     = 1'b0;
        mem_delay    = 0;
        mem_write    = 1'b0;
        mem_addr     = '0;
        mem_wdata    = '0;
        expect_write = 1'b0;
        expect_box   = '0;
        expect_rec   = '0;
        out_count    = 0;
        req_count    = 0;
        write_count  = 0;
        count_ok     = 0;
        count_exp    = 0;
        count_ing    = 0;

        for (i = 0; i < 256; i++)
        begin
            rec.black_tea       = random_amount();
            rec.green_tea       = random_amount();
            rec.milk            = random_amount();
            rec.pineapple_juice = random_amount();
            rec.exp_month       = month_t'(6 + rand_below(7));
            rec.exp_day         = day_t'(1 + rand_below(31));
            rec.pad             = '0;
            mem[i]              = rec;
            ref_mem[i]          = rec;
        end

        repeat (3) @(posedge clk);
        inf <= 1'b1;

        // Nothing moves before the first order
        for (i = 0; i < 5; i++)
        begin
            tick();
            check_err("idle err_msg", No_Err, seen_err);
            check_complete("idle complete", 1'b0, seen_complete);
        end
        if (out_count != 0 || req_count != 0)
        begin
            $display("Output or memory activity seen before the first order");
            abort_run();
        end

        for (i = 0; i < NUM_ORDERS; i++)
            run_order(i);

        $display("Results: %0d no error, %0d expired, %0d short", count_ok, count_exp,
                 count_ing);
        if (count_ok == 0 || count_exp == 0 || count_ing == 0)
        begin
            $display("Not every kind of result was reached by the random orders");
            abort_run();
        end
        else
        begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/bev_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module bev_controller
    import bev_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    inf,
    input  wire logic    order_ready,
    input  wire order_t  order,
    input  wire logic    done,
    input  wire record_t rdata,
    input  wire err_t    err,
    input  wire record_t new_record,
    output logic         busy,
    output order_t       recipe_order,
    output record_t      recipe_record,
    output logic         req,
    output logic         write,
    output box_t         addr,
    output record_t      wdata,
    output logic         out_valid,
    output err_t         err_msg,
    output logic         complete
);

    typedef enum logic [2:0] {
        IDLE,
        READ,
        EVAL,
        WRITE,
        REPORT
    } ctl_state_t;

    ctl_state_t state;
    order_t     order_q;
    record_t    record_q;
    record_t    new_q;
    err_t       err_q;
    logic       mem_wait;

    assign busy          = order_ready || state != IDLE;
    assign recipe_order  = order_q;
    assign recipe_record = record_q;
    assign addr          = order_q.box;
    assign wdata         = new_q;

    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
        begin
            state     <= IDLE;
            req       <= 1'b0;
            write     <= 1'b0;
            out_valid <= 1'b0;
            err_msg   <= No_Err;
            complete  <= 1'b0;
        end
        else
        begin
            req       <= 1'b0;
            out_valid <= 1'b0;
            case (state)
                IDLE:
                    if (order_ready)
                    begin
                        req   <= 1'b1;
                        write <= 1'b0;
                        state <= READ;
                    end
                READ:
                    if (done)
                        state <= EVAL;
                EVAL:
                    // Only a successful drink changes the box
                    if (order_q.action == Make_drink && err == No_Err)
                    begin
                        req   <= 1'b1;
                        write <= 1'b1;
                        state <= WRITE;
                    end
                    else
                    begin
                        out_valid <= 1'b1;
                        err_msg   <= err;
                        complete  <= (err == No_Err);
                        state     <= REPORT;
                    end
                WRITE:
                    if (done)
                    begin
                        out_valid <= 1'b1;
                        err_msg   <= err_q;
                        complete  <= (err_q == No_Err);
                        state     <= REPORT;
                    end
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == IDLE && order_ready)
            order_q <= order;
        if (state == READ && done)
            record_q <= rdata;
        if (state == EVAL)
        begin
            err_q <= err;
            new_q <= new_record;
        end
    end

    // Open request, from req until the port answers
    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
            mem_wait <= 1'b0;
        else if (req)
            mem_wait <= 1'b1;
        else if (done)
            mem_wait <= 1'b0;
    end

    assert property (@(posedge clk) disable iff (!inf) req |-> !mem_wait);
    assert property (@(posedge clk) disable iff (!inf) out_valid |=> !out_valid);

endmodule

`default_nettype wire

// ==== verilog/bev_dram_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bev_settings.svh"

module bev_dram_port
    import bev_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   inf,
    input  wire logic                   req,
    input  wire logic                   write,
    input  wire box_t                   addr,
    input  wire record_t                wdata,
    input  wire logic                   c_out_valid,
    input  wire logic [`BEV_DATA_W-1:0] c_data_r,
    output logic                        done,
    output record_t                     rdata,
    output logic                        c_in_valid,
    output logic                        c_r_wb,
    output box_t                        c_addr,
    output logic [`BEV_DATA_W-1:0]      c_data_w
);

    logic pending;

    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
        begin
            c_in_valid <= 1'b0;
            pending    <= 1'b0;
            done       <= 1'b0;
        end
        else
        begin
            c_in_valid <= req;
            done       <= c_out_valid;
            if (req)
                pending <= 1'b1;
            else if (c_out_valid)
                pending <= 1'b0;
        end
    end

    // Request fields stay put until the next req
    always_ff @(posedge clk)
    begin
        if (req)
        begin
            c_r_wb   <= !write;
            c_addr   <= addr;
            c_data_w <= wdata;
        end
        if (c_out_valid && c_r_wb)
            rdata <= record_t'(c_data_r);
    end

    assert property (@(posedge clk) disable iff (!inf) c_out_valid |-> pending);
    assert property (@(posedge clk) disable iff (!inf) req |-> !pending);

endmodule

`default_nettype wire

// ==== verilog/bev_order_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module bev_order_capture
    import bev_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     inf,
    input  wire logic     action_valid,
    input  wire logic     type_valid,
    input  wire logic     size_valid,
    input  wire logic     date_valid,
    input  wire logic     box_valid,
    input  wire in_data_t in_data,
    input  wire logic     busy,
    output logic          order_ready,
    output order_t        order
);

    typedef enum logic [2:0] {
        CAP_ACT,
        CAP_TYPE,
        CAP_SIZE,
        CAP_DATE,
        CAP_BOX
    } cap_state_t;

    cap_state_t state;
    logic [4:0] strobes;
    logic [4:0] expected;
    logic [4:0] take;

    // Bit order is action, type, size, date, box
    assign strobes = {action_valid, type_valid, size_valid, date_valid, box_valid};

    always_comb
    begin
        case (state)
            CAP_TYPE: expected = 5'b01000;
            CAP_SIZE: expected = 5'b00100;
            CAP_DATE: expected = 5'b00010;
            CAP_BOX:  expected = 5'b00001;
            default:  expected = 5'b10000;
        endcase
    end

    // A new action waits until the previous order has reported
    assign take = strobes & expected & {!busy, 4'b1111};

    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
        begin
            state       <= CAP_ACT;
            order_ready <= 1'b0;
        end
        else
        begin
            order_ready <= 1'b0;
            if (take[4])
                state <= (action_t'(in_data[0]) == Make_drink) ? CAP_TYPE : CAP_DATE;
            else if (take[3])
                state <= CAP_SIZE;
            else if (take[2])
                state <= CAP_DATE;
            else if (take[1])
                state <= CAP_BOX;
            else if (take[0])
            begin
                state       <= CAP_ACT;
                order_ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (take[4])
            order.action <= action_t'(in_data[0]);
        if (take[3])
            order.bev_type <= bev_type_t'(in_data[2:0]);
        if (take[2])
            order.size <= bev_size_t'(in_data[1:0]);
        if (take[1])
            order.date <= date_t'(in_data);
        if (take[0])
            order.box <= box_t'(in_data[`BEV_BOX_W-1:0]);
    end

    // Fields come in the fixed order for the current action
    assert property (@(posedge clk) disable iff (!inf) (strobes & ~expected) == 5'b00000);

endmodule

`default_nettype wire

// ==== verilog/bev_pkg.sv ====
`default_nettype none

`include "bev_settings.svh"

package bev_pkg;

    typedef logic [`BEV_ING_W-1:0] ing_t;
    typedef logic [3:0]            month_t;
    typedef logic [4:0]            day_t;
    typedef logic [`BEV_BOX_W-1:0] box_t;
    typedef logic [8:0]            in_data_t;

    typedef enum logic [0:0] {
        Make_drink,
        Check_valid_date
    } action_t;

    typedef enum logic [2:0] {
        Black_Tea,
        Milk_Tea,
        Extra_Milk_Tea,
        Green_Tea,
        Green_Milk_Tea,
        Pineapple_Juice,
        Super_Pineapple_Tea,
        Super_Pineapple_Milk_Tea
    } bev_type_t;

    typedef enum logic [1:0] {
        S,
        M,
        L
    } bev_size_t;

    typedef enum logic [1:0] {
        No_Err,
        No_Exp,
        No_Ing
    } err_t;

    // Month in the upper bits, as on the input bus
    typedef struct packed {
        month_t month;
        day_t   day;
    } date_t;

    typedef struct packed {
        action_t   action;
        bev_type_t bev_type;
        bev_size_t size;
        date_t     date;
        box_t      box;
    } order_t;

    // Memory word layout, black tea in the top bits
    typedef struct packed {
        ing_t       black_tea;
        ing_t       green_tea;
        ing_t       milk;
        ing_t       pineapple_juice;
        month_t     exp_month;
        day_t       exp_day;
        logic [6:0] pad;
    } record_t;

endpackage

`default_nettype wire

// ==== verilog/bev_recipe.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bev_settings.svh"

module bev_recipe
    import bev_pkg::*;
(
    input  wire order_t  order,
    input  wire record_t record,
    output record_t      new_record,
    output err_t         err
);

    ing_t vol;
    ing_t half;
    ing_t quarter;
    ing_t need_black;
    ing_t need_green;
    ing_t need_milk;
    ing_t need_pine;
    logic expired;
    logic lacking;

    always_comb
    begin
        case (order.size)
            M:       vol = ing_t'(`BEV_VOL_M);
            L:       vol = ing_t'(`BEV_VOL_L);
            default: vol = ing_t'(`BEV_VOL_S);
        endcase
    end

    // All volumes divide by four
    assign half    = vol >> 1;
    assign quarter = vol >> 2;

    always_comb
    begin
        need_black = '0;
        need_green = '0;
        need_milk  = '0;
        need_pine  = '0;
        case (order.bev_type)
            Black_Tea:
                need_black = vol;
            Milk_Tea:
            begin
                need_black = vol - quarter;
                need_milk  = quarter;
            end
            Extra_Milk_Tea:
            begin
                need_black = half;
                need_milk  = half;
            end
            Green_Tea:
                need_green = vol;
            Green_Milk_Tea:
            begin
                need_green = half;
                need_milk  = half;
            end
            Pineapple_Juice:
                need_pine = vol;
            Super_Pineapple_Tea:
            begin
                need_black = half;
                need_pine  = half;
            end
            Super_Pineapple_Milk_Tea:
            begin
                need_black = half;
                need_pine  = quarter;
                need_milk  = quarter;
            end
        endcase
    end

    // Still good on the expiry day itself
    assign expired = (record.exp_month < order.date.month) ||
                     (record.exp_month == order.date.month && record.exp_day < order.date.day);

    assign lacking = (need_black > record.black_tea) || (need_green > record.green_tea) ||
                     (need_milk > record.milk) || (need_pine > record.pineapple_juice);

    always_comb
    begin
        new_record                 = record;
        new_record.black_tea       = record.black_tea - need_black;
        new_record.green_tea       = record.green_tea - need_green;
        new_record.milk            = record.milk - need_milk;
        new_record.pineapple_juice = record.pineapple_juice - need_pine;
    end

    always_comb
    begin
        if (expired)
            err = No_Exp;
        else if (order.action == Make_drink && lacking)
            err = No_Ing;
        else
            err = No_Err;
    end

endmodule

`default_nettype wire

// ==== verilog/bev_settings.svh ====
`ifndef BEV_SETTINGS_SVH
`define BEV_SETTINGS_SVH

// Ingredient amount width and its largest value
`define BEV_ING_W   12
`define BEV_ING_MAX 4095

// Box number, also the memory address
`define BEV_BOX_W   8

// One memory word holds one box record
`define BEV_DATA_W  64

// Cup volumes
`define BEV_VOL_S   480
`define BEV_VOL_M   720
`define BEV_VOL_L   960

`endif

// ==== verilog/bev_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module bev_top
    import bev_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     inf,
    input  wire logic     action_valid,
    input  wire logic     type_valid,
    input  wire logic     size_valid,
    input  wire logic     date_valid,
    input  wire logic     box_valid,
    input  wire in_data_t in_data,
    input  wire logic     c_out_valid,
    input  wire record_t  c_data_r,
    output logic          out_valid,
    output err_t          err_msg,
    output logic          complete,
    output logic          c_in_valid,
    output logic          c_r_wb,
    output box_t          c_addr,
    output record_t       c_data_w
);

    logic    order_ready;
    logic    busy;
    order_t  order;
    order_t  recipe_order;
    record_t recipe_record;
    record_t new_record;
    err_t    err;
    logic    req;
    logic    write;
    box_t    addr;
    record_t wdata;
    logic    done;
    record_t rdata;

    bev_order_capture u_capture (
        .clk          (clk),
        .inf          (inf),
        .action_valid (action_valid),
        .type_valid   (type_valid),
        .size_valid   (size_valid),
        .date_valid   (date_valid),
        .box_valid    (box_valid),
        .in_data      (in_data),
        .busy         (busy),
        .order_ready  (order_ready),
        .order        (order)
    );

    bev_controller u_ctrl (
        .clk           (clk),
        .inf           (inf),
        .order_ready   (order_ready),
        .order         (order),
        .done          (done),
        .rdata         (rdata),
        .err           (err),
        .new_record    (new_record),
        .busy          (busy),
        .recipe_order  (recipe_order),
        .recipe_record (recipe_record),
        .req           (req),
        .write         (write),
        .addr          (addr),
        .wdata         (wdata),
        .out_valid     (out_valid),
        .err_msg       (err_msg),
        .complete      (complete)
    );

    bev_recipe u_recipe (
        .order      (recipe_order),
        .record     (recipe_record),
        .new_record (new_record),
        .err        (err)
    );

    bev_dram_port u_port (
        .clk         (clk),
        .inf         (inf),
        .req         (req),
        .write       (write),
        .addr        (addr),
        .wdata       (wdata),
        .c_out_valid (c_out_valid),
        .c_data_r    (c_data_r),
        .done        (done),
        .rdata       (rdata),
        .c_in_valid  (c_in_valid),
        .c_r_wb      (c_r_wb),
        .c_addr      (c_addr),
        .c_data_w    (c_data_w)
    );

endmodule

`default_nettype wire
